// File: all.f
+incdir+common
common/fpexp_pkg.sv
hdl/fpexp_axil_regs.sv
hdl/exp_dispatch.sv
exp_lane/exp_lane.sv
hdl/exp_collect.sv
hdl/fpexp_top.sv
tb/fpexp_props.sv
tb/fpexp_tb.sv

// File: run.sh
#!/bin/sh
# build the fpexp testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails
verilator --binary --timing --assert -Wno-fatal \
	--top-module fpexp_tb -f all.f -o fpexp_sim \
	&& ./obj_dir/fpexp_sim \
	|| exit 1

// File: tb/fpexp_tb.sv
/*
	fpexp testbench
	table-driven check of the exponent section over AXI4-Lite:
	reset state, single commands, ordering, back-pressure and SLVERR
*/

`timescale 1ns/1ps
`include "fpexp_params.svh"

module fpexp_tb;

	// register map
	// 0x0 CMD     a in [7:0], b in [15:8], op in [17:16]
	// 0x4 RESULT  [31] valid, [12] far, [11] unf, [10] ovf, [9:0] sum, a read pops
	// 0x8 COUNT   result FIFO fill level
	localparam logic [`FPEXP_ADDR_W-1:0] A_CMD = 'h0;
	localparam logic [`FPEXP_ADDR_W-1:0] A_RESULT = 'h4;
	localparam logic [`FPEXP_ADDR_W-1:0] A_COUNT = 'h8;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;
	localparam int N_FIXED = 15;
	localparam int N = 25;

	logic f2strob;
	logic _0_d_;
	logic [`FPEXP_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`FPEXP_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	fpexp_pkg::exp_op_t tbl_op [N];
	logic [7:0] tbl_a [N];
	logic [7:0] tbl_b [N];
	logic [31:0] tbl_exp [N];
	integer seed;
	int errors;
	int aw_hs;
	int ar_hs;

	fpexp_top i_fpexp_top (.*);

	bind fpexp_top fpexp_props i_props (
		.f2strob    (f2strob),
		._0_d_      (_0_d_),
		.bvalid     (bvalid),
		.bready     (bready),
		.rvalid     (rvalid),
		.rready     (rready),
		.count      (count),
		.lane_ready (lane_ready),
		.res_valid  (res_valid)
	);

	initial begin
		f2strob = 1'b0;
		forever #50 f2strob = ~f2strob;
	end

	// address handshakes, counted on the edge where they happen
	always @(posedge f2strob) begin
		if (awvalid && awready && wvalid && wready)
			aw_hs++;
		if (arvalid && arready)
			ar_hs++;
	end

	task automatic abort_run();
		errors++;
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare_word(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] time %0d ns %s expected 0x%08h actual 0x%08h",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_resp(string name, logic [1:0] expected, logic [1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] time %0d ns %s expected %0d actual %0d",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic expect_flag(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("[ERROR] time %0d ns %s expected %b actual %b",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	// sum and flags straight from the opcode rules
	function automatic logic [31:0] expected_word(fpexp_pkg::exp_op_t op, logic [7:0] a,
		logic [7:0] b);
		int sa;
		int sb;
		int s;
		logic [31:0] w;
		sa = $signed(a);
		sb = $signed(b);
		case (op)
			fpexp_pkg::OP_MUL: s = sa + sb;
			fpexp_pkg::OP_DIV: s = sa - sb - 1;
			default: s = sa - sb;
		endcase
		w = 32'h8000_0000;
		w[9:0] = s[9:0];
		w[10] = (op != fpexp_pkg::OP_ALIGN) && (s > 127);
		w[11] = (op != fpexp_pkg::OP_ALIGN) && (s < -128);
		w[12] = (op == fpexp_pkg::OP_ALIGN) && ((s >= 40) || (s <= -40));
		return w;
	endfunction

	task automatic set_entry(int i, fpexp_pkg::exp_op_t op, int a, int b);
		tbl_op[i] = op;
		tbl_a[i] = 8'(a);
		tbl_b[i] = 8'(b);
		tbl_exp[i] = expected_word(op, 8'(a), 8'(b));
	endtask

	task automatic build_table();
		int r;
		int a;
		int b;
		set_entry(0, fpexp_pkg::OP_ALIGN, 10, 3);
		set_entry(1, fpexp_pkg::OP_ALIGN, 50, 5);
		set_entry(2, fpexp_pkg::OP_ALIGN, -20, 25);
		set_entry(3, fpexp_pkg::OP_ALIGN, 127, -128);
		set_entry(4, fpexp_pkg::OP_ALIGN, -128, 127);
		set_entry(5, fpexp_pkg::OP_ALIGN, 39, 0);
		set_entry(6, fpexp_pkg::OP_ALIGN, 0, 40);
		set_entry(7, fpexp_pkg::OP_MUL, 100, 27);
		set_entry(8, fpexp_pkg::OP_MUL, 100, 28);
		set_entry(9, fpexp_pkg::OP_MUL, -128, -1);
		set_entry(10, fpexp_pkg::OP_MUL, 127, 127);
		set_entry(11, fpexp_pkg::OP_DIV, -128, 0);
		set_entry(12, fpexp_pkg::OP_DIV, 127, -1);
		set_entry(13, fpexp_pkg::OP_DIV, -128, 127);
		set_entry(14, fpexp_pkg::OP_DIV, 127, -2);
		for (int i = N_FIXED; i < N; i++) begin
			r = $random(seed);
			a = $random(seed);
			b = $random(seed);
			set_entry(i, fpexp_pkg::exp_op_t'(2'((r & 32'h7fff_ffff) % 3)), a, b);
		end
	endtask

	function automatic logic [31:0] cmd_word(int i);
		return {14'd0, tbl_op[i], tbl_b[i], tbl_a[i]};
	endfunction

	task automatic start_write(logic [`FPEXP_ADDR_W-1:0] addr, logic [31:0] data);
		@(negedge f2strob);
		aw_hs = 0;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
	endtask

	task automatic finish_write(output logic [1:0] resp);
		int cycles;
		cycles = 0;
		while (!bvalid) begin
			@(negedge f2strob);
			cycles++;
			if (cycles > 50) begin
				$display("write to address 0x%0h was never accepted", awaddr);
				abort_run();
			end
		end
		expect_flag("awready/wready", 1'b1, aw_hs == 1);
		resp = bresp;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		@(negedge f2strob);
		bready = 1'b0;
	endtask

	task automatic bus_read(logic [`FPEXP_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int cycles;
		@(negedge f2strob);
		ar_hs = 0;
		araddr = addr;
		arvalid = 1'b1;
		cycles = 0;
		while (!rvalid) begin
			@(negedge f2strob);
			cycles++;
			if (cycles > 50) begin
				$display("read of address 0x%0h got no data back", addr);
				abort_run();
			end
		end
		expect_flag("arready", 1'b1, ar_hs == 1);
		data = rdata;
		resp = rresp;
		arvalid = 1'b0;
		rready = 1'b1;
		@(negedge f2strob);
		rready = 1'b0;
	endtask

	task automatic send_cmd(int i);
		logic [1:0] resp;
		start_write(A_CMD, cmd_word(i));
		finish_write(resp);
		check_resp("bresp", OKAY, resp);
	endtask

	// poll COUNT until the FIFO holds at least this many results
	task automatic wait_count(int least);
		logic [31:0] data;
		logic [1:0] resp;
		for (int polls = 0; polls < 40; polls++) begin
			bus_read(A_COUNT, data, resp);
			check_resp("rresp", OKAY, resp);
			if (data >= 32'(least))
				return;
		end
		$display("result FIFO never reached %0d entries", least);
		abort_run();
	endtask

	task automatic pop_and_check(int i);
		logic [31:0] data;
		logic [1:0] resp;
		wait_count(1);
		bus_read(A_RESULT, data, resp);
		check_resp("rresp", OKAY, resp);
		compare_word("rdata", tbl_exp[i], data);
	endtask

	initial begin : main
		logic [31:0] data;
		logic [1:0] resp;
		_0_d_ = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		errors = 0;
		aw_hs = 0;
		ar_hs = 0;
		seed = 71;
		build_table();
		repeat (5) @(negedge f2strob);
		_0_d_ = 1'b1;

		expect_flag("bvalid", 1'b0, bvalid);
		expect_flag("rvalid", 1'b0, rvalid);
		bus_read(A_COUNT, data, resp);
		compare_word("count", 32'd0, data);
		bus_read(A_RESULT, data, resp);
		check_resp("rresp", OKAY, resp);
		expect_flag("rdata[31]", 1'b0, data[31]);

		// one command at a time
		for (int i = 0; i < N; i++) begin
			send_cmd(i);
			pop_and_check(i);
		end

		// eight in flight come back in command order
		for (int i = 0; i < 8; i++)
			send_cmd(i);
		for (int i = 0; i < 8; i++)
			pop_and_check(i);

		// lanes and FIFO full, so the ninth write has to wait for a pop
		for (int i = 8; i < 16; i++)
			send_cmd(i);
		wait_count(4);
		start_write(A_CMD, cmd_word(16));
		repeat (20) begin
			@(negedge f2strob);
			expect_flag("awready", 1'b0, awready);
			expect_flag("wready", 1'b0, wready);
			expect_flag("bvalid", 1'b0, bvalid);
		end
		pop_and_check(8);
		finish_write(resp);
		check_resp("bresp", OKAY, resp);
		for (int i = 9; i < 17; i++)
			pop_and_check(i);

		// illegal opcode and unmapped accesses
		start_write(A_CMD, 32'h0003_0102);
		finish_write(resp);
		check_resp("bresp", SLVERR, resp);
		start_write(A_RESULT, 32'h0000_0102);
		finish_write(resp);
		check_resp("bresp", SLVERR, resp);
		bus_read('hC, data, resp);
		check_resp("rresp", SLVERR, resp);
		compare_word("rdata", 32'd0, data);
		repeat (10) @(negedge f2strob);
		bus_read(A_COUNT, data, resp);
		compare_word("count", 32'd0, data);

		if (errors == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "errors found");
		end
	end

	initial begin : watchdog
		repeat (N * 200) @(posedge f2strob);
		$display("watchdog expired after %0d cycles, the tests did not finish", N * 200);
		abort_run();
	end

endmodule

// File: tb/fpexp_props.sv
/*
	fpexp assertions
	AXI response hold, FIFO level bound and lane handshake exclusion
*/

`timescale 1ns/1ps
`include "fpexp_params.svh"

module fpexp_props (
	input logic f2strob,
	input logic _0_d_,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic [$clog2(`FPEXP_FIFO_DEPTH):0] count,
	input logic [`FPEXP_LANES-1:0] lane_ready,
	input logic [`FPEXP_LANES-1:0] res_valid
);

	// responses hold until taken
	a_bvalid_hold: assert property (@(posedge f2strob) disable iff (!_0_d_)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge f2strob) disable iff (!_0_d_)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	a_count_max: assert property (@(posedge f2strob) disable iff (!_0_d_)
		count <= `FPEXP_FIFO_DEPTH)
		else $error("result FIFO count above its depth");

	// a lane either takes a command or holds a result
	a_lane_excl: assert property (@(posedge f2strob) disable iff (!_0_d_)
		(lane_ready & res_valid) == '0)
		else $error("lane ready while holding a result");

endmodule

// File: hdl/fpexp_top.sv
/*
	fpexp top level
	AXI4-Lite register block, round-robin dispatcher,
	exponent lanes and result collector
*/

`timescale 1ns/1ps
`include "fpexp_params.svh"

module fpexp_top (
	input  logic f2strob,
	input  logic _0_d_,
	input  logic [`FPEXP_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`FPEXP_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready
);

	logic cmd_valid;
	logic cmd_ready;
	fpexp_pkg::exp_op_t cmd_op;
	logic [fpexp_pkg::EXP_W-1:0] cmd_a;
	logic [fpexp_pkg::EXP_W-1:0] cmd_b;
	logic [`FPEXP_LANES-1:0] lane_valid;
	logic [`FPEXP_LANES-1:0] lane_ready;
	fpexp_pkg::exp_op_t lane_op [`FPEXP_LANES];
	logic [fpexp_pkg::EXP_W-1:0] lane_a [`FPEXP_LANES];
	logic [fpexp_pkg::EXP_W-1:0] lane_b [`FPEXP_LANES];
	logic [`FPEXP_LANES-1:0] res_valid;
	logic [`FPEXP_LANES-1:0] res_ready;
	logic [fpexp_pkg::SUM_W-1:0] res_sum [`FPEXP_LANES];
	logic [`FPEXP_LANES-1:0] res_ovf;
	logic [`FPEXP_LANES-1:0] res_unf;
	logic [`FPEXP_LANES-1:0] res_far;
	logic pop;
	logic [fpexp_pkg::RES_W-1:0] head;
	logic [$clog2(`FPEXP_FIFO_DEPTH):0] count;

	fpexp_axil_regs i_regs (.*);

	exp_dispatch i_dispatch (.*);

	// identical lanes
	for (genvar g = 0; g < `FPEXP_LANES; g++) begin : g_lane
		exp_lane i_lane (
			.f2strob   (f2strob),
			._0_d_     (_0_d_),
			.in_valid  (lane_valid[g]),
			.in_op     (lane_op[g]),
			.in_a      (lane_a[g]),
			.in_b      (lane_b[g]),
			.res_ready (res_ready[g]),
			.in_ready  (lane_ready[g]),
			.res_valid (res_valid[g]),
			.res_sum   (res_sum[g]),
			.res_ovf   (res_ovf[g]),
			.res_unf   (res_unf[g]),
			.res_far   (res_far[g])
		);
	end

	exp_collect i_collect (.*);

endmodule

// File: hdl/exp_collect.sv
/*
	exponent result collector
	drains the lanes in round-robin order into the result FIFO
	and reports its fill level
*/

`timescale 1ns/1ps
`include "fpexp_params.svh"

module exp_collect (
	input  logic f2strob,
	input  logic _0_d_,
	input  logic [`FPEXP_LANES-1:0] res_valid,
	input  logic [fpexp_pkg::SUM_W-1:0] res_sum [`FPEXP_LANES],
	input  logic [`FPEXP_LANES-1:0] res_ovf,
	input  logic [`FPEXP_LANES-1:0] res_unf,
	input  logic [`FPEXP_LANES-1:0] res_far,
	input  logic pop,
	output logic [`FPEXP_LANES-1:0] res_ready,
	output logic [fpexp_pkg::RES_W-1:0] head,
	output logic [$clog2(`FPEXP_FIFO_DEPTH):0] count
);

	localparam int PTR_W = $clog2(`FPEXP_LANES);
	localparam int AW = $clog2(`FPEXP_FIFO_DEPTH);

	logic [PTR_W-1:0] ptr;
	logic [fpexp_pkg::RES_W-1:0] mem [`FPEXP_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic full;
	logic push;
	logic do_pop;
	logic [fpexp_pkg::RES_W-1:0] word;

	assign full = (count == (AW + 1)'(`FPEXP_FIFO_DEPTH));
	assign push = res_valid[ptr] && !full;
	assign do_pop = pop && (count != '0);
	assign word = {res_far[ptr], res_unf[ptr], res_ovf[ptr], res_sum[ptr]};
	assign head = mem[rd_ptr];

	always_comb begin
		for (int i = 0; i < `FPEXP_LANES; i++)
			res_ready[i] = !full && (ptr == PTR_W'(i));
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			ptr <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
				if (ptr == PTR_W'(`FPEXP_LANES - 1))
					ptr <= '0;
				else
					ptr <= ptr + 1'b1;
			end
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// push and pop together leave the level alone
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge f2strob) begin
		if (push)
			mem[wr_ptr] <= word;
	end

endmodule

// File: exp_lane/exp_lane.sv
/*
	exponent lane
	D and B registers, B bus select, 10-bit exponent adder
	and range checks for ALIGN, MUL and DIV
*/

`timescale 1ns/1ps

module exp_lane (
	input  logic f2strob,
	input  logic _0_d_,
	input  logic in_valid,
	input  fpexp_pkg::exp_op_t in_op,
	input  logic [fpexp_pkg::EXP_W-1:0] in_a,
	input  logic [fpexp_pkg::EXP_W-1:0] in_b,
	input  logic res_ready,
	output logic in_ready,
	output logic res_valid,
	output logic [fpexp_pkg::SUM_W-1:0] res_sum,
	output logic res_ovf,
	output logic res_unf,
	output logic res_far
);

	localparam int EXP_W = fpexp_pkg::EXP_W;
	localparam int SUM_W = fpexp_pkg::SUM_W;

	// B bus select
	localparam logic [1:0] BSEL_COMP = 2'd0;
	localparam logic [1:0] BSEL_TRUE = 2'd1;
	localparam logic [1:0] BSEL_ONES = 2'd2;
	localparam logic [1:0] BSEL_ZERO = 2'd3;

	fpexp_pkg::lane_state_t state;
	fpexp_pkg::exp_op_t op;
	logic [SUM_W-1:0] d_reg;
	logic [EXP_W-1:0] b_reg;
	logic [1:0] b_sel;
	logic [EXP_W-1:0] b_bus;
	logic cin;
	logic [SUM_W-1:0] sum;
	logic signed [SUM_W-1:0] sum_s;
	logic ovf;
	logic unf;
	logic far;

	assign in_ready = (state == fpexp_pkg::LANE_IDLE);

	always_comb begin
		b_sel = BSEL_ZERO;
		if (state == fpexp_pkg::LANE_ADD) begin
			case (op)
				fpexp_pkg::OP_MUL: b_sel = BSEL_TRUE;
				fpexp_pkg::OP_ALIGN, fpexp_pkg::OP_DIV: b_sel = BSEL_COMP;
				default: b_sel = BSEL_ONES;
			endcase
		end
	end

	always_comb begin
		case (b_sel)
			BSEL_COMP: b_bus = ~b_reg;
			BSEL_TRUE: b_bus = b_reg;
			BSEL_ONES: b_bus = '1;
			default: b_bus = '0;
		endcase
	end

	// carry in turns the complement into a true subtract
	assign cin = (state == fpexp_pkg::LANE_ADD) && (op == fpexp_pkg::OP_ALIGN);
	assign sum = d_reg + {{(SUM_W - EXP_W){b_bus[EXP_W-1]}}, b_bus}
		+ {{(SUM_W - 1){1'b0}}, cin};
	assign sum_s = signed'(sum);

	assign ovf = (op != fpexp_pkg::OP_ALIGN) && (sum_s > 127);
	assign unf = (op != fpexp_pkg::OP_ALIGN) && (sum_s < -128);
	// mantissa shifted out completely
	assign far = (op == fpexp_pkg::OP_ALIGN) && ((sum_s >= 40) || (sum_s <= -40));

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			state <= fpexp_pkg::LANE_IDLE;
			res_valid <= 1'b0;
		end else begin
			case (state)
				fpexp_pkg::LANE_IDLE: begin
					if (in_valid)
						state <= fpexp_pkg::LANE_ADD;
				end
				fpexp_pkg::LANE_ADD: state <= fpexp_pkg::LANE_DONE;
				fpexp_pkg::LANE_DONE: begin
					if (!res_valid) begin
						res_valid <= 1'b1;
					end else if (res_ready) begin
						res_valid <= 1'b0;
						state <= fpexp_pkg::LANE_IDLE;
					end
				end
				default: state <= fpexp_pkg::LANE_IDLE;
			endcase
		end
	end

	// operands and registered sum
	always_ff @(posedge f2strob) begin
		if (in_valid && in_ready) begin
			d_reg <= {{(SUM_W - EXP_W){in_a[EXP_W-1]}}, in_a};
			b_reg <= in_b;
			op <= in_op;
		end
		if (state == fpexp_pkg::LANE_ADD) begin
			res_sum <= sum;
			res_ovf <= ovf;
			res_unf <= unf;
			res_far <= far;
		end
	end

endmodule

// File: hdl/exp_dispatch.sv
/*
	exponent command dispatcher
	hands each command to the next lane in round-robin order,
	stalls while that lane is still busy
*/

`timescale 1ns/1ps
`include "fpexp_params.svh"

module exp_dispatch (
	input  logic f2strob,
	input  logic _0_d_,
	input  logic cmd_valid,
	input  fpexp_pkg::exp_op_t cmd_op,
	input  logic [fpexp_pkg::EXP_W-1:0] cmd_a,
	input  logic [fpexp_pkg::EXP_W-1:0] cmd_b,
	input  logic [`FPEXP_LANES-1:0] lane_ready,
	output logic cmd_ready,
	output logic [`FPEXP_LANES-1:0] lane_valid,
	output fpexp_pkg::exp_op_t lane_op [`FPEXP_LANES],
	output logic [fpexp_pkg::EXP_W-1:0] lane_a [`FPEXP_LANES],
	output logic [fpexp_pkg::EXP_W-1:0] lane_b [`FPEXP_LANES]
);

	localparam int PTR_W = $clog2(`FPEXP_LANES);

	logic [PTR_W-1:0] ptr;

	// only the selected lane counts, so results stay in order
	assign cmd_ready = lane_ready[ptr];

	always_comb begin
		for (int i = 0; i < `FPEXP_LANES; i++) begin
			lane_valid[i] = cmd_valid && (ptr == PTR_W'(i));
			lane_op[i] = (ptr == PTR_W'(i)) ? cmd_op : fpexp_pkg::OP_ALIGN;
			lane_a[i] = (ptr == PTR_W'(i)) ? cmd_a : '0;
			lane_b[i] = (ptr == PTR_W'(i)) ? cmd_b : '0;
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			ptr <= '0;
		end else if (cmd_valid && cmd_ready) begin
			if (ptr == PTR_W'(`FPEXP_LANES - 1))
				ptr <= '0;
			else
				ptr <= ptr + 1'b1;
		end
	end

endmodule

// File: hdl/fpexp_axil_regs.sv
/*
	fpexp AXI4-Lite register block
	decodes CMD, RESULT and COUNT, issues exponent commands
	to the dispatcher and pops the result FIFO on RESULT reads
*/

`timescale 1ns/1ps
`include "fpexp_params.svh"

module fpexp_axil_regs (
	input  logic f2strob,
	input  logic _0_d_,
	input  logic [`FPEXP_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`FPEXP_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic cmd_ready,
	input  logic [fpexp_pkg::RES_W-1:0] head,
	input  logic [$clog2(`FPEXP_FIFO_DEPTH):0] count,
	output logic cmd_valid,
	output fpexp_pkg::exp_op_t cmd_op,
	output logic [fpexp_pkg::EXP_W-1:0] cmd_a,
	output logic [fpexp_pkg::EXP_W-1:0] cmd_b,
	output logic pop
);

	localparam logic [`FPEXP_ADDR_W-1:0] ADDR_CMD = 'h0;
	localparam logic [`FPEXP_ADDR_W-1:0] ADDR_RESULT = 'h4;
	localparam logic [`FPEXP_ADDR_W-1:0] ADDR_COUNT = 'h8;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam int CNT_W = $clog2(`FPEXP_FIFO_DEPTH) + 1;

	logic op_legal;
	logic wr_legal;
	logic wr_req;
	logic wr_fire;
	logic rd_fire;
	logic res_avail;
	logic [31:0] rd_word;
	logic [1:0] rd_resp;

	// command fields straight from the write data
	assign cmd_op = fpexp_pkg::exp_op_t'(wdata[17:16]);
	assign cmd_a = wdata[7:0];
	assign cmd_b = wdata[15:8];

	always_comb begin
		case (cmd_op)
			fpexp_pkg::OP_ALIGN, fpexp_pkg::OP_MUL, fpexp_pkg::OP_DIV: op_legal = 1'b1;
			default: op_legal = 1'b0;
		endcase
	end

	assign wr_legal = (awaddr == ADDR_CMD) && op_legal;
	assign wr_req = awvalid && wvalid && !bvalid;
	assign cmd_valid = wr_req && wr_legal;
	// a legal command waits for its lane, anything else completes with SLVERR
	assign wr_fire = wr_req && (!wr_legal || cmd_ready);
	assign awready = wr_fire;
	assign wready = wr_fire;

	assign arready = !rvalid;
	assign rd_fire = arvalid && arready;
	assign res_avail = (count != '0);
	assign pop = rd_fire && (araddr == ADDR_RESULT) && res_avail;

	always_comb begin
		rd_word = 32'd0;
		rd_resp = RESP_OKAY;
		case (araddr)
			ADDR_RESULT: begin
				if (res_avail)
					rd_word = {1'b1, {(31 - fpexp_pkg::RES_W){1'b0}}, head};
			end
			ADDR_COUNT: rd_word = {{(32 - CNT_W){1'b0}}, count};
			default: rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// response payload
	always_ff @(posedge f2strob) begin
		if (wr_fire)
			bresp <= wr_legal ? RESP_OKAY : RESP_SLVERR;
		if (rd_fire) begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

endmodule

// File: common/fpexp_pkg.sv
/*
	fpexp package
	types shared by the exponent section of the FPU:
	opcodes, lane states and result field widths
*/

package fpexp_pkg;

	// exponent and sum widths, sum has two sign-extension bits on top
	localparam int EXP_W = 8;
	localparam int SUM_W = 10;
	// packed result word: far, underflow, overflow, sum
	localparam int RES_W = SUM_W + 3;

	// register map
	//   0x0 CMD    wo  [7:0] a, [15:8] b, [17:16] op
	//   0x4 RESULT ro  [31] valid, [12] far, [11] unf, [10] ovf, [9:0] sum
	//                  a read pops the result FIFO
	//   0x8 COUNT  ro  result FIFO fill level
	//   others         SLVERR

	// encoding 2'b11 is illegal
	typedef enum logic [1:0] {
		OP_ALIGN = 2'b00,
		OP_MUL   = 2'b01,
		OP_DIV   = 2'b10
	} exp_op_t;

	typedef enum logic [1:0] {
		LANE_IDLE = 2'b00,
		LANE_ADD  = 2'b01,
		LANE_DONE = 2'b10
	} lane_state_t;

endpackage

// File: common/fpexp_params.svh
/*
	fpexp parameters
	lane count, result FIFO depth and AXI4-Lite address width
*/

`ifndef FPEXP_PARAMS_SVH
`define FPEXP_PARAMS_SVH

// 2, 4 or 8 lanes
`define FPEXP_LANES 4

// power of two
`define FPEXP_FIFO_DEPTH 4

`define FPEXP_ADDR_W 4

`endif
